// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_pat
FLIST ?= pat.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -Wno-fatal -j 0
PASS_MSG ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: pat.f
+incdir+.
pat_pkg.sv
pat_alu.sv
pat_dmem.sv
pat_fetch.sv
pat_decode.sv
pat_commit.sv
pat.sv
tb_pat.sv

// File: pat.sv
`include "pat_params.svh"

module pat (
	input logic clk,
	input logic reset,
	output logic [`PAT_PC_WIDTH-1:0] o_pc,
	input logic [`PAT_I_WIDTH-1:0] i_instruction,
	output logic [`PAT_FIELDP_WIDTH-1:0] o_fieldp,
	input logic [`PAT_D_WIDTH-1:0] i_field_low,
	input logic [`PAT_D_WIDTH-1:0] i_field_high,
	output logic o_field_we_low,
	output logic o_field_we_high,
	output logic [`PAT_FIELDP_WIDTH-1:0] o_fieldwp,
	output logic [`PAT_D_WIDTH-1:0] o_field_data,
	input logic [`PAT_D_WIDTH-1:0] i_in0,
	input logic [`PAT_D_WIDTH-1:0] i_in1,
	input logic [`PAT_D_WIDTH-1:0] i_in2,
	output logic [`PAT_D_WIDTH-1:0] o_out,
	output logic o_out_valid,
	output logic o_jump
) ;

	import pat_pkg::* ;

	// fetch -> decode
	pat_instr_u f_instr ;
	logic [`PAT_PC_WIDTH-1:0] f_pc ;
	logic [`PAT_PC_WIDTH-1:0] target ;

	// decode -> execute
	logic d_valid, d_field_op, d_use_mem ;
	logic [`PAT_PC_WIDTH-1:0] d_pc ;
	logic [1:0] d_cond ;
	pat_alu_fn_e d_fn ;
	logic [`PAT_D_WIDTH-1:0] d_imm, d_field_low, d_field_high ;
	logic [`PAT_DMEM_ADR_WIDTH-1:0] d_mem_adr ;
	logic [`PAT_FIELDP_WIDTH-1:0] d_fieldp ;
	logic d_branch, d_store, d_test, d_out, d_setb, d_in, d_mov, d_result ;

	// execute
	logic [`PAT_D_WIDTH-1:0] acc, acc_result, field_byte, field_result ;
	logic [`PAT_D_WIDTH-1:0] mem_rd, mem_wr_data ;
	logic mem_we ;

	pat_fetch fetch0 (.clk, .reset, .i_instruction, .i_jump(o_jump), .i_target(target),
		.o_pc, .o_instr(f_instr), .o_instr_pc(f_pc)) ;

	pat_decode decode0 (.clk, .reset, .i_instr(f_instr), .i_instr_pc(f_pc), .i_jump(o_jump),
		.i_field_low, .i_field_high, .o_fieldp, .o_valid(d_valid), .o_pc(d_pc),
		.o_cond(d_cond), .o_field_op(d_field_op), .o_alu_fn(d_fn), .o_use_mem(d_use_mem),
		.o_imm(d_imm), .o_mem_adr(d_mem_adr), .o_field_low_q(d_field_low),
		.o_field_high_q(d_field_high), .o_fieldp_q(d_fieldp), .o_is_branch(d_branch),
		.o_is_store(d_store), .o_is_test(d_test), .o_is_out(d_out), .o_is_setb(d_setb),
		.o_is_in(d_in), .o_is_mov(d_mov), .o_writes_result(d_result)) ;

	pat_alu acc_alu (.i_a(acc), .i_imm(d_imm), .i_mem(mem_rd), .i_use_mem(d_use_mem),
		.i_fn(d_fn), .o_result(acc_result)) ;

	pat_alu field_alu (.i_a(field_byte), .i_imm(d_imm), .i_mem(mem_rd), .i_use_mem(d_use_mem),
		.i_fn(d_fn), .o_result(field_result)) ;

	// one address field serves ldm-style reads and stm
	pat_dmem dmem0 (.clk, .i_rd_adr(d_mem_adr), .i_wr_adr(d_mem_adr), .i_we(mem_we),
		.i_wr_data(mem_wr_data), .o_rd_data(mem_rd)) ;

	pat_commit commit0 (.clk, .reset, .i_valid(d_valid), .i_pc(d_pc), .i_cond(d_cond),
		.i_field_op(d_field_op), .i_imm(d_imm), .i_field_low_q(d_field_low),
		.i_field_high_q(d_field_high), .i_fieldp_q(d_fieldp), .i_is_branch(d_branch),
		.i_is_store(d_store), .i_is_test(d_test), .i_is_out(d_out), .i_is_setb(d_setb),
		.i_is_in(d_in), .i_is_mov(d_mov), .i_writes_result(d_result),
		.i_acc_result(acc_result), .i_field_result(field_result), .i_mem_data(mem_rd),
		.i_in0, .i_in1, .i_in2, .o_acc(acc), .o_field_sel_high(),
		.o_field_sel_byte(field_byte), .o_jump, .o_target(target), .o_mem_we(mem_we),
		.o_mem_wr_data(mem_wr_data), .o_field_we_low, .o_field_we_high, .o_fieldwp,
		.o_field_data, .o_out, .o_out_valid) ;

endmodule

// File: pat_alu.sv
`include "pat_params.svh"

module pat_alu (
	input logic [`PAT_D_WIDTH-1:0] i_a, // acc or selected field byte
	input logic [`PAT_D_WIDTH-1:0] i_imm,
	input logic [`PAT_D_WIDTH-1:0] i_mem, // data memory word
	input logic i_use_mem,
	input pat_pkg::pat_alu_fn_e i_fn,
	output logic [`PAT_D_WIDTH-1:0] o_result
) ;

	import pat_pkg::* ;

	logic [`PAT_D_WIDTH-1:0] b ;
	logic [2:0] sh ; // shift amount
	logic [`PAT_D_WIDTH-1:0] ones ;

	assign b = i_use_mem ? i_mem : i_imm ;
	assign sh = i_imm[2:0] ;
	assign ones = ~({`PAT_D_WIDTH{1'b1}} << sh) ; // low sh bits set, for shlo

	always_comb
	begin
		case (i_fn)
			ALU_OR: o_result = i_a | b ;
			ALU_AND: o_result = i_a & b ;
			ALU_ADD: o_result = i_a + b ; // wraps
			ALU_SUB: o_result = i_a - b ;
			ALU_NOT: o_result = ~i_a ;
			ALU_SHL: o_result = i_a << sh ;
			ALU_SHLO: o_result = (i_a << sh) | ones ;
			ALU_SHR: o_result = i_a >> sh ;
			ALU_ASR: o_result = $unsigned($signed(i_a) >>> sh) ; // sign fill
			default: o_result = b ; // pass, ldi and ldm
		endcase
	end

endmodule

// File: pat_commit.sv
`include "pat_params.svh"

module pat_commit (
	input logic clk,
	input logic reset,
	input logic i_valid,
	input logic [`PAT_PC_WIDTH-1:0] i_pc,
	input logic [1:0] i_cond,
	input logic i_field_op,
	input logic [`PAT_D_WIDTH-1:0] i_imm,
	input logic [`PAT_D_WIDTH-1:0] i_field_low_q,
	input logic [`PAT_D_WIDTH-1:0] i_field_high_q,
	input logic [`PAT_FIELDP_WIDTH-1:0] i_fieldp_q,
	input logic i_is_branch,
	input logic i_is_store,
	input logic i_is_test,
	input logic i_is_out,
	input logic i_is_setb,
	input logic i_is_in,
	input logic i_is_mov,
	input logic i_writes_result,
	input logic [`PAT_D_WIDTH-1:0] i_acc_result,
	input logic [`PAT_D_WIDTH-1:0] i_field_result,
	input logic [`PAT_D_WIDTH-1:0] i_mem_data,
	input logic [`PAT_D_WIDTH-1:0] i_in0,
	input logic [`PAT_D_WIDTH-1:0] i_in1,
	input logic [`PAT_D_WIDTH-1:0] i_in2,
	output logic [`PAT_D_WIDTH-1:0] o_acc,
	output logic o_field_sel_high,
	output logic [`PAT_D_WIDTH-1:0] o_field_sel_byte,
	output logic o_jump,
	output logic [`PAT_PC_WIDTH-1:0] o_target,
	output logic o_mem_we,
	output logic [`PAT_D_WIDTH-1:0] o_mem_wr_data,
	output logic o_field_we_low,
	output logic o_field_we_high,
	output logic [`PAT_FIELDP_WIDTH-1:0] o_fieldwp,
	output logic [`PAT_D_WIDTH-1:0] o_field_data,
	output logic [`PAT_D_WIDTH-1:0] o_out,
	output logic o_out_valid
) ;

	import pat_pkg::* ;

	logic z, n ; // flags, set by test only
	logic cond_ok ;
	logic commit ;
	logic field_dest ; // result goes to the selected buffer
	logic [`PAT_D_WIDTH-1:0] in_sel ;
	logic [`PAT_D_WIDTH-1:0] test_val ;

	// ====================
	// condition and select
	// ====================
	always_comb
	begin
		case (i_cond)
			COND_Z: cond_ok = z ;
			COND_NZ: cond_ok = !z ;
			COND_N: cond_ok = n ;
			default: cond_ok = 1'b1 ; // COND_AL
		endcase
	end

	assign commit = i_valid && cond_ok ;
	assign o_field_sel_byte = o_field_sel_high ? i_field_high_q : i_field_low_q ;
	assign field_dest = i_field_op && (i_writes_result || i_is_mov) ;
	assign test_val = i_field_op ? o_field_sel_byte : o_acc ;

	always_comb
	begin
		case (i_imm[2:0]) // one-hot input select
			3'b010: in_sel = i_in1 ;
			3'b100: in_sel = i_in2 ;
			default: in_sel = i_in0 ;
		endcase
	end

	// branch and memory write land on the commit edge itself
	assign o_jump = commit && i_is_branch ;
	assign o_target = i_pc + {{(`PAT_PC_WIDTH-`PAT_D_WIDTH){i_imm[`PAT_D_WIDTH-1]}}, i_imm} ;
	assign o_mem_we = commit && i_is_store ;
	assign o_mem_wr_data = i_field_op ? o_field_sel_byte : o_acc ; // stm acc or field

	// ====================
	// architectural state
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0 ;
			z <= 1'b0 ;
			n <= 1'b0 ;
			o_field_sel_high <= 1'b0 ;
			o_field_we_low <= 1'b0 ;
			o_field_we_high <= 1'b0 ;
			o_out_valid <= 1'b0 ;
		end
		else
		begin
			o_field_we_low <= commit && field_dest && !o_field_sel_high ;
			o_field_we_high <= commit && field_dest && o_field_sel_high ;
			o_out_valid <= commit && i_is_out ; // one-cycle pulse
			if (commit)
			begin
				if (i_writes_result && !i_field_op)
					o_acc <= i_acc_result ;
				if (i_is_in)
					o_acc <= in_sel ;
				if (i_is_mov && !i_field_op)
					o_acc <= o_field_sel_byte ; // field -> acc
				if (i_is_test)
				begin
					z <= (test_val == '0) ;
					n <= test_val[`PAT_D_WIDTH-1] ;
				end
				if (i_is_setb)
					o_field_sel_high <= i_imm[3] ;
			end
		end
	end

	// write payload, qualified by the enables above
	always_ff @(posedge clk)
	begin
		o_fieldwp <= i_fieldp_q ; // own pointer, no delay line
		o_field_data <= i_is_mov ? o_acc : i_field_result ; // acc -> field on mov
		if (commit && i_is_out)
			o_out <= o_acc ;
	end

	a_one_side : assert property (@(posedge clk) disable iff (reset)
		!(o_field_we_low && o_field_we_high))
		else $error("both field buffers written") ;

endmodule

// File: pat_decode.sv
`include "pat_params.svh"

module pat_decode (
	input logic clk,
	input logic reset,
	input pat_pkg::pat_instr_u i_instr,
	input logic [`PAT_PC_WIDTH-1:0] i_instr_pc,
	input logic i_jump, // kill the instruction being registered
	input logic [`PAT_D_WIDTH-1:0] i_field_low,
	input logic [`PAT_D_WIDTH-1:0] i_field_high,
	output logic [`PAT_FIELDP_WIDTH-1:0] o_fieldp, // read pointer to the buffers
	output logic o_valid,
	output logic [`PAT_PC_WIDTH-1:0] o_pc,
	output logic [1:0] o_cond,
	output logic o_field_op,
	output pat_pkg::pat_alu_fn_e o_alu_fn,
	output logic o_use_mem,
	output logic [`PAT_D_WIDTH-1:0] o_imm,
	output logic [`PAT_DMEM_ADR_WIDTH-1:0] o_mem_adr,
	output logic [`PAT_D_WIDTH-1:0] o_field_low_q,
	output logic [`PAT_D_WIDTH-1:0] o_field_high_q,
	output logic [`PAT_FIELDP_WIDTH-1:0] o_fieldp_q, // becomes the write pointer
	output logic o_is_branch,
	output logic o_is_store,
	output logic o_is_test,
	output logic o_is_out,
	output logic o_is_setb,
	output logic o_is_in,
	output logic o_is_mov,
	output logic o_writes_result
) ;

	import pat_pkg::* ;

	logic fmt8, fmt3 ; // fmt0 when neither
	pat_alu_fn_e fn ;
	logic use_mem ;
	logic is_branch, is_store, is_test, is_out, is_setb, is_in, is_mov, writes_result ;

	assign o_fieldp = i_instr.long_v.fieldp ;
	assign fmt8 = (i_instr.long_v.opcode != FMT_PREFIX) ;
	assign fmt3 = !fmt8 && (i_instr.short_v.sub_opcode != FMT_PREFIX) ;

	// ====================
	// opcode classes
	// ====================
	always_comb
	begin
		fn = ALU_PASS ;
		use_mem = 1'b0 ;
		is_branch = 1'b0 ;
		is_store = 1'b0 ;
		is_test = 1'b0 ;
		is_out = 1'b0 ;
		is_setb = 1'b0 ;
		is_in = 1'b0 ;
		is_mov = 1'b0 ;
		writes_result = 1'b0 ;
		if (fmt8)
		begin
			case (i_instr.long_v.opcode)
				OP8_OR, OP8_ORM: fn = ALU_OR ;
				OP8_AND, OP8_ANDM: fn = ALU_AND ;
				OP8_ADD, OP8_ADDM: fn = ALU_ADD ;
				OP8_SUB, OP8_SUBM: fn = ALU_SUB ;
				default: fn = ALU_PASS ; // ldi, ldm
			endcase
			case (i_instr.long_v.opcode)
				OP8_ORM, OP8_ANDM, OP8_ADDM, OP8_SUBM, OP8_LDM: use_mem = 1'b1 ;
				default: use_mem = 1'b0 ;
			endcase
			case (i_instr.long_v.opcode)
				OP8_OR, OP8_AND, OP8_ADD, OP8_SUB, OP8_LDI: writes_result = 1'b1 ;
				OP8_ORM, OP8_ANDM, OP8_ADDM, OP8_SUBM, OP8_LDM: writes_result = 1'b1 ;
				OP8_BF: is_branch = 1'b1 ;
				OP8_STM: is_store = 1'b1 ;
				default: writes_result = 1'b0 ; // unused codes fall through as nop
			endcase
		end
		else if (fmt3)
		begin
			case (i_instr.short_v.sub_opcode)
				OP3_SHL: fn = ALU_SHL ;
				OP3_SHLO: fn = ALU_SHLO ;
				OP3_SHR: fn = ALU_SHR ;
				OP3_ASR: fn = ALU_ASR ;
				default: fn = ALU_PASS ;
			endcase
			case (i_instr.short_v.sub_opcode)
				OP3_SHL, OP3_SHLO, OP3_SHR, OP3_ASR: writes_result = 1'b1 ;
				OP3_IN: is_in = 1'b1 ;
				OP3_OUT: is_out = 1'b1 ;
				OP3_SETB: is_setb = 1'b1 ;
				default: writes_result = 1'b0 ;
			endcase
		end
		else
		begin
			case (i_instr.short_v.low)
				OP0_NOT:
				begin
					fn = ALU_NOT ;
					writes_result = 1'b1 ;
				end
				OP0_MOV: is_mov = 1'b1 ; // direction from field_op
				OP0_TEST: is_test = 1'b1 ;
				default: fn = ALU_PASS ; // OP0_NOP and unused
			endcase
		end
	end

	// ====================
	// execute stage register
	// ====================
	always_ff @(posedge clk)
	begin
		if (reset || i_jump)
			o_valid <= 1'b0 ;
		else
			o_valid <= 1'b1 ;
	end

	always_ff @(posedge clk)
	begin
		o_pc <= i_instr_pc ;
		o_cond <= i_instr.long_v.cond ;
		o_field_op <= i_instr.long_v.field_op ;
		o_alu_fn <= fn ;
		o_use_mem <= use_mem ;
		// short formats carry a 4-bit immediate, shifts and in read [2:0], setb bit 3
		o_imm <= fmt8 ? i_instr.long_v.imm8 : {4'h0, i_instr.short_v.low} ;
		o_mem_adr <= i_instr.long_v.imm8[`PAT_DMEM_ADR_WIDTH-1:0] ;
		o_field_low_q <= i_field_low ; // both bytes, commit picks the side
		o_field_high_q <= i_field_high ;
		o_fieldp_q <= i_instr.long_v.fieldp ;
		o_is_branch <= is_branch ;
		o_is_store <= is_store ;
		o_is_test <= is_test ;
		o_is_out <= is_out ;
		o_is_setb <= is_setb ;
		o_is_in <= is_in ;
		o_is_mov <= is_mov ;
		o_writes_result <= writes_result ;
	end

	// commit relies on a single destination per instruction
	a_one_dest : assert property (@(posedge clk) disable iff (reset)
		o_valid |-> $onehot0({o_is_branch, o_is_store, o_is_test, o_is_out,
			o_is_setb, o_is_in, o_is_mov, o_writes_result}))
		else $error("more than one destination decoded") ;

endmodule

// File: pat_dmem.sv
`include "pat_params.svh"

module pat_dmem (
	input logic clk,
	input logic [`PAT_DMEM_ADR_WIDTH-1:0] i_rd_adr,
	input logic [`PAT_DMEM_ADR_WIDTH-1:0] i_wr_adr,
	input logic i_we,
	input logic [`PAT_D_WIDTH-1:0] i_wr_data,
	output logic [`PAT_D_WIDTH-1:0] o_rd_data
) ;

	logic [`PAT_D_WIDTH-1:0] mem [`PAT_DMEM_WORDS] ;

	assign o_rd_data = mem[i_rd_adr] ; // async read, next instruction sees the write

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_wr_adr] <= i_wr_data ;
	end

	a_wr_adr_known : assert property (@(posedge clk) i_we |-> !$isunknown(i_wr_adr))
		else $error("dmem write with X address") ;

endmodule

// File: pat_fetch.sv
`include "pat_params.svh"

module pat_fetch (
	input logic clk,
	input logic reset,
	input logic [`PAT_I_WIDTH-1:0] i_instruction, // program memory word at o_pc
	input logic i_jump, // branch committing this cycle
	input logic [`PAT_PC_WIDTH-1:0] i_target,
	output logic [`PAT_PC_WIDTH-1:0] o_pc,
	output pat_pkg::pat_instr_u o_instr,
	output logic [`PAT_PC_WIDTH-1:0] o_instr_pc
) ;

	import pat_pkg::* ;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_pc <= '0 ;
			o_instr <= INSTR_NOP ; // pipeline starts empty
			o_instr_pc <= '0 ;
		end
		else if (i_jump)
		begin
			o_pc <= i_target ;
			o_instr <= INSTR_NOP ; // squash the word fetched behind the branch
			o_instr_pc <= o_pc ;
		end
		else
		begin
			o_pc <= o_pc + 1'b1 ;
			o_instr <= i_instruction ;
			o_instr_pc <= o_pc ; // address travels with its word
		end
	end

	// a bad target or a missed reset would show up here first
	a_pc_known : assert property (@(posedge clk) disable iff (reset) !$isunknown(o_pc))
		else $error("pc holds X") ;

endmodule

// File: pat_params.svh
`ifndef PAT_PARAMS_SVH
`define PAT_PARAMS_SVH

// ====================
// core sizes
// ====================
`define PAT_I_WIDTH 20 // instruction word
`define PAT_D_WIDTH 8 // acc, field bytes, data memory words
`define PAT_PC_WIDTH 10 // external program memory address
`define PAT_FIELDP_WIDTH 5 // 32-entry field buffers

// data memory
`define PAT_DMEM_WORDS 8
`define PAT_DMEM_ADR_WIDTH 3

`endif

// File: pat_pkg.sv
`include "pat_params.svh"

package pat_pkg ;

	// one instruction word, two views
	// i8 uses the long view, i3 and i0 the short one
	typedef union packed {
		struct packed {
			logic [`PAT_FIELDP_WIDTH-1:0] fieldp ;
			logic [1:0] cond ;
			logic field_op ; // 0 acc, 1 field
			logic [3:0] opcode ;
			logic [7:0] imm8 ;
		} long_v ;
		struct packed {
			logic [`PAT_FIELDP_WIDTH-1:0] fieldp ;
			logic [1:0] cond ;
			logic field_op ;
			logic [3:0] prefix ; // all ones here
			logic [3:0] sub_opcode ; // i3 opcode, or prefix again for i0
			logic [3:0] low ; // i3 immediate in [2:0], i0 opcode
		} short_v ;
	} pat_instr_u ;

	localparam logic [3:0] FMT_PREFIX = 4'hf ; // escape i8 -> i3 -> i0

	// i8 opcodes
	localparam logic [3:0] OP8_OR = 4'd0, OP8_AND = 4'd1, OP8_ADDM = 4'd2, OP8_SUBM = 4'd3 ;
	localparam logic [3:0] OP8_ADD = 4'd4, OP8_SUB = 4'd5, OP8_LDI = 4'd6, OP8_LDM = 4'd7 ;
	localparam logic [3:0] OP8_BF = 4'd8, OP8_STM = 4'd11, OP8_ORM = 4'd13, OP8_ANDM = 4'd14 ;
	// i3 opcodes
	localparam logic [3:0] OP3_SHL = 4'd0, OP3_SHLO = 4'd1, OP3_SHR = 4'd2, OP3_ASR = 4'd3 ;
	localparam logic [3:0] OP3_IN = 4'd5, OP3_OUT = 4'd8, OP3_SETB = 4'd9 ;
	// i0 opcodes
	localparam logic [3:0] OP0_NOT = 4'd0, OP0_MOV = 4'd1, OP0_TEST = 4'd2, OP0_NOP = 4'd15 ;

	// condition field
	localparam logic [1:0] COND_Z = 2'd0, COND_NZ = 2'd1, COND_N = 2'd2, COND_AL = 2'd3 ;

	typedef enum logic [3:0] {
		ALU_PASS, ALU_OR, ALU_AND, ALU_ADD, ALU_SUB,
		ALU_NOT, ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR
	} pat_alu_fn_e ;

	// fieldp 0, always, acc side, i0 nop
	localparam logic [`PAT_I_WIDTH-1:0] INSTR_NOP = 20'h06fff ;

endpackage

// File: tb_pat_cases.svh
`ifndef TB_PAT_CASES_SVH
`define TB_PAT_CASES_SVH

// programs end in a branch to self, unused slots hold nops
task automatic fill_case_table ;
	// ====================
	// 0 acc immediate ops, in from in2
	// ====================
	prog_tab[0] = '{long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'h05),
		short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_ADD, 8'h0a), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_SUB, 8'h20), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_OR, 8'h10), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_AND, 8'h3c), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		bare_word(COND_AL, 1'b0, 5'd0, OP0_NOT), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		short_word(COND_AL, 1'b0, 5'd0, OP3_IN, 4'b0100), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_BF, 8'h00), INSTR_NOP} ;
	in_tab[0] = '{8'h00, 8'h00, 8'h5a} ;
	out_tab[0] = '{8'h05, 8'h0f, 8'hef, 8'hff, 8'h3c, 8'hc3, 8'h5a, 8'h00} ; // sub wraps
	out_cnt[0] = 7 ;
	fw_tab[0] = '{14'h0, 14'h0, 14'h0, 14'h0} ;
	fw_cnt[0] = 0 ;
	land_tab[0] = 10'd14 ;
	// ====================
	// 1 shifts, in0 and in1
	// ====================
	prog_tab[1] = '{long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'hc1),
		short_word(COND_AL, 1'b0, 5'd0, OP3_SHL, 4'd1), short_word(COND_AL, 1'b0, 5'd0, OP3_SHR, 4'd3),
		short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0), long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'h90),
		short_word(COND_AL, 1'b0, 5'd0, OP3_ASR, 4'd2), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		short_word(COND_AL, 1'b0, 5'd0, OP3_SHLO, 4'd3), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		short_word(COND_AL, 1'b0, 5'd0, OP3_SHLO, 4'd1), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		short_word(COND_AL, 1'b0, 5'd0, OP3_IN, 4'b0001), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		short_word(COND_AL, 1'b0, 5'd0, OP3_IN, 4'b0010), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_BF, 8'h00)} ;
	in_tab[1] = '{8'h11, 8'h22, 8'h33} ;
	out_tab[1] = '{8'h10, 8'he4, 8'h27, 8'h4f, 8'h11, 8'h22, 8'h00, 8'h00} ; // asr keeps sign
	out_cnt[1] = 6 ;
	fw_tab[1] = '{14'h0, 14'h0, 14'h0, 14'h0} ;
	fw_cnt[1] = 0 ;
	land_tab[1] = 10'd15 ;
	// ====================
	// 2 data memory
	// ====================
	prog_tab[2] = '{long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'h30),
		long_word(COND_AL, 1'b0, 5'd0, OP8_STM, 8'h01), long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'h0c),
		long_word(COND_AL, 1'b0, 5'd0, OP8_STM, 8'h02), long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'hf0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_STM, 8'h03), long_word(COND_AL, 1'b0, 5'd0, OP8_LDM, 8'h01),
		long_word(COND_AL, 1'b0, 5'd0, OP8_ADDM, 8'h02), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_SUBM, 8'h03), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_ORM, 8'h03), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_ANDM, 8'h02), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_BF, 8'h00)} ;
	in_tab[2] = '{8'h00, 8'h00, 8'h00} ;
	out_tab[2] = '{8'h3c, 8'h4c, 8'hfc, 8'h0c, 8'h00, 8'h00, 8'h00, 8'h00} ;
	out_cnt[2] = 4 ;
	fw_tab[2] = '{14'h0, 14'h0, 14'h0, 14'h0} ;
	fw_cnt[2] = 0 ;
	land_tab[2] = 10'd15 ;
	// ====================
	// 3 field path, low[i] = 3i+1, high[i] = f0^i
	// ====================
	prog_tab[3] = '{short_word(COND_AL, 1'b0, 5'd0, OP3_SETB, 4'b0000),
		long_word(COND_AL, 1'b1, 5'd2, OP8_ADD, 8'h10), long_word(COND_AL, 1'b1, 5'd3, OP8_OR, 8'h81),
		short_word(COND_AL, 1'b0, 5'd0, OP3_SETB, 4'b1000), short_word(COND_AL, 1'b1, 5'd4, OP3_SHL, 4'd2),
		bare_word(COND_AL, 1'b0, 5'd5, OP0_MOV), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'h66), bare_word(COND_AL, 1'b1, 5'd6, OP0_MOV),
		long_word(COND_AL, 1'b1, 5'd7, OP8_STM, 8'h00), short_word(COND_AL, 1'b0, 5'd0, OP3_SETB, 4'b0000),
		long_word(COND_AL, 1'b0, 5'd0, OP8_LDM, 8'h00), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_BF, 8'h00), INSTR_NOP, INSTR_NOP} ;
	in_tab[3] = '{8'h00, 8'h00, 8'h00} ;
	out_tab[3] = '{8'hf5, 8'hf7, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00} ; // high[5], high[7]
	out_cnt[3] = 2 ;
	fw_tab[3] = '{{1'b0, 5'd2, 8'h17}, {1'b0, 5'd3, 8'h8b}, {1'b1, 5'd4, 8'hd0},
		{1'b1, 5'd6, 8'h66}} ;
	fw_cnt[3] = 4 ;
	land_tab[3] = 10'd13 ;
	// ====================
	// 4 conditions and a forward branch
	// ====================
	prog_tab[4] = '{long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'h00),
		bare_word(COND_AL, 1'b0, 5'd0, OP0_TEST), short_word(COND_NZ, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_Z, 1'b0, 5'd0, OP8_LDI, 8'h11), short_word(COND_Z, 1'b0, 5'd0, OP3_OUT, 4'd0),
		short_word(COND_AL, 1'b0, 5'd0, OP3_SETB, 4'b1000), bare_word(COND_AL, 1'b1, 5'd9, OP0_TEST),
		short_word(COND_N, 1'b0, 5'd0, OP3_OUT, 4'd0), long_word(COND_Z, 1'b0, 5'd0, OP8_LDI, 8'h22),
		long_word(COND_AL, 1'b0, 5'd0, OP8_BF, 8'h03), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_BF, 8'h00), INSTR_NOP, INSTR_NOP} ;
	in_tab[4] = '{8'h00, 8'h00, 8'h00} ;
	out_tab[4] = '{8'h11, 8'h11, 8'h11, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00} ;
	out_cnt[4] = 3 ; // the two outs behind the branch never show
	fw_tab[4] = '{14'h0, 14'h0, 14'h0, 14'h0} ;
	fw_cnt[4] = 0 ;
	land_tab[4] = 10'd12 ; // bf at 9, +3
	// 5 backward loop counting down from 3
	prog_tab[5] = '{long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'h03),
		short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0), long_word(COND_AL, 1'b0, 5'd0, OP8_SUB, 8'h01),
		bare_word(COND_AL, 1'b0, 5'd0, OP0_TEST), long_word(COND_NZ, 1'b0, 5'd0, OP8_BF, 8'hfd),
		long_word(COND_AL, 1'b0, 5'd0, OP8_LDI, 8'h55), short_word(COND_AL, 1'b0, 5'd0, OP3_OUT, 4'd0),
		long_word(COND_AL, 1'b0, 5'd0, OP8_BF, 8'h00), INSTR_NOP, INSTR_NOP, INSTR_NOP, INSTR_NOP,
		INSTR_NOP, INSTR_NOP, INSTR_NOP, INSTR_NOP} ;
	in_tab[5] = '{8'h00, 8'h00, 8'h00} ;
	out_tab[5] = '{8'h03, 8'h02, 8'h01, 8'h55, 8'h00, 8'h00, 8'h00, 8'h00} ;
	out_cnt[5] = 4 ;
	fw_tab[5] = '{14'h0, 14'h0, 14'h0, 14'h0} ;
	fw_cnt[5] = 0 ;
	land_tab[5] = 10'd1 ; // bf at 4, -3, back to the out
endtask

`endif

// File: tb_pat.sv
`include "pat_params.svh"

module tb_pat ;

	import pat_pkg::* ;

	localparam int NCASES = 6 ;
	localparam int PROG_WORDS = 16 ;
	localparam int MAX_OUTS = 8 ;
	localparam int MAX_FW = 4 ;
	localparam int BUF_WORDS = 32 ;
	localparam int OUT_TIMEOUT = 200 ; // cycles allowed to reach all expected outs
	localparam int DRAIN_CYCLES = 24 ; // late field writes, stray outs

	logic clk ;
	logic reset ;
	logic [`PAT_PC_WIDTH-1:0] pc ;
	logic [`PAT_I_WIDTH-1:0] instr ;
	logic [`PAT_FIELDP_WIDTH-1:0] fieldp ;
	logic [`PAT_D_WIDTH-1:0] field_low, field_high ;
	logic we_low, we_high ;
	logic [`PAT_FIELDP_WIDTH-1:0] fieldwp ;
	logic [`PAT_D_WIDTH-1:0] field_data ;
	logic [`PAT_D_WIDTH-1:0] in0, in1, in2 ;
	logic [`PAT_D_WIDTH-1:0] out ;
	logic out_valid ;
	logic jump ;

	// ====================
	// case table storage
	// ====================
	logic [`PAT_I_WIDTH-1:0] prog_tab [NCASES][PROG_WORDS] ;
	logic [`PAT_D_WIDTH-1:0] in_tab [NCASES][3] ; // in0, in1, in2
	logic [`PAT_D_WIDTH-1:0] out_tab [NCASES][MAX_OUTS] ;
	int out_cnt [NCASES] ;
	logic [13:0] fw_tab [NCASES][MAX_FW] ; // {side high, pointer, data}
	int fw_cnt [NCASES] ;
	logic [`PAT_PC_WIDTH-1:0] land_tab [NCASES] ; // pc right after the first taken branch

	// models of the external memories
	logic [`PAT_I_WIDTH-1:0] prog [PROG_WORDS] ;
	logic [`PAT_D_WIDTH-1:0] buf_low [BUF_WORDS] ;
	logic [`PAT_D_WIDTH-1:0] buf_high [BUF_WORDS] ;
	logic load_buffers ; // reload initial buffer contents at the next edge

	logic [`PAT_D_WIDTH-1:0] seen_out [$] ;
	logic [13:0] seen_fw [$] ;
	logic [`PAT_PC_WIDTH-1:0] seen_land [$] ;
	logic jump_seen ; // o_jump at the previous falling edge
	int errors ;
	int checks ;

	// i8 word: pointer, condition, field_op, opcode, imm8
	function automatic logic [`PAT_I_WIDTH-1:0] long_word(input logic [1:0] c, input logic f,
		input logic [4:0] p, input logic [3:0] op, input logic [7:0] imm) ;
		long_word = {p, c, f, op, imm} ;
	endfunction

	// i3 word, prefix escape then sub opcode
	function automatic logic [`PAT_I_WIDTH-1:0] short_word(input logic [1:0] c, input logic f,
		input logic [4:0] p, input logic [3:0] op, input logic [3:0] imm) ;
		short_word = {p, c, f, FMT_PREFIX, op, imm} ;
	endfunction

	// i0 word, prefix twice
	function automatic logic [`PAT_I_WIDTH-1:0] bare_word(input logic [1:0] c, input logic f,
		input logic [4:0] p, input logic [3:0] op) ;
		bare_word = {p, c, f, FMT_PREFIX, FMT_PREFIX, op} ;
	endfunction

	`include "tb_pat_cases.svh"

	// words past the program read as nop
	assign instr = (pc < PROG_WORDS) ? prog[pc[3:0]] : INSTR_NOP ;
	assign field_low = buf_low[fieldp] ; // combinational buffer read
	assign field_high = buf_high[fieldp] ;

	pat dut0 (.clk, .reset, .o_pc(pc), .i_instruction(instr), .o_fieldp(fieldp),
		.i_field_low(field_low), .i_field_high(field_high), .o_field_we_low(we_low),
		.o_field_we_high(we_high), .o_fieldwp(fieldwp), .o_field_data(field_data),
		.i_in0(in0), .i_in1(in1), .i_in2(in2), .o_out(out), .o_out_valid(out_valid),
		.o_jump(jump)) ;

	initial
	begin
		clk = 1'b0 ;
		forever #4 clk = ~clk ;
	end

	// buffers take the DUT write at the clock edge
	always @(posedge clk)
	begin
		for (int i = 0 ; i < BUF_WORDS ; i++)
		begin
			if (load_buffers)
			begin
				buf_low[i] <= 8'(3 * i + 1) ;
				buf_high[i] <= 8'hf0 ^ 8'(i) ;
			end
		end
		if (!load_buffers && we_low)
			buf_low[fieldwp] <= field_data ;
		if (!load_buffers && we_high)
			buf_high[fieldwp] <= field_data ;
	end

	// ====================
	// monitor, outputs are stable at the falling edge
	// ====================
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (out_valid)
				seen_out.push_back(out) ;
			if (we_low)
				seen_fw.push_back({1'b0, fieldwp, field_data}) ;
			if (we_high)
				seen_fw.push_back({1'b1, fieldwp, field_data}) ;
			if (jump_seen)
				seen_land.push_back(pc) ; // pc has loaded the target by now
		end
		jump_seen = !reset && jump ;
	end

	task automatic run_case(input int c) ;
		int waited ;
		int errs_before ;
		errs_before = errors ;
		@(negedge clk) ;
		reset = 1'b1 ;
		load_buffers = 1'b1 ;
		in0 = in_tab[c][0] ;
		in1 = in_tab[c][1] ;
		in2 = in_tab[c][2] ;
		for (int k = 0 ; k < PROG_WORDS ; k++)
			prog[k] = prog_tab[c][k] ;
		repeat (4) @(negedge clk) ; // 4 reset edges
		seen_out.delete() ;
		seen_fw.delete() ;
		seen_land.delete() ;
		load_buffers = 1'b0 ;
		reset = 1'b0 ;
		waited = 0 ;
		while (seen_out.size() < out_cnt[c] && waited < OUT_TIMEOUT)
		begin
			@(negedge clk) ;
			waited++ ;
		end
		if (seen_out.size() < out_cnt[c])
		begin
			$display("case %0d: timed out waiting for o_out_valid, %0d of %0d outputs seen",
				c, seen_out.size(), out_cnt[c]) ;
			errors++ ;
		end
		repeat (DRAIN_CYCLES) @(negedge clk) ; // nothing more may appear
		checks++ ;
		assert (seen_out.size() == out_cnt[c])
		else
		begin
			$display("MISMATCH at %0t: case %0d gave %0d outputs, expected %0d", $time, c,
				seen_out.size(), out_cnt[c]) ;
			errors++ ;
		end
		for (int k = 0 ; k < out_cnt[c] && k < seen_out.size() ; k++)
		begin
			checks++ ;
			assert (seen_out[k] == out_tab[c][k])
			else
			begin
				$display("MISMATCH at %0t: case %0d out %0d is %h, expected %h", $time, c, k,
					seen_out[k], out_tab[c][k]) ;
				errors++ ;
			end
		end
		checks++ ;
		assert (seen_fw.size() == fw_cnt[c])
		else
		begin
			$display("MISMATCH at %0t: case %0d gave %0d field writes, expected %0d", $time, c,
				seen_fw.size(), fw_cnt[c]) ;
			errors++ ;
		end
		for (int k = 0 ; k < fw_cnt[c] && k < seen_fw.size() ; k++)
		begin
			checks++ ;
			assert (seen_fw[k] == fw_tab[c][k]) // side, pointer and data together
			else
			begin
				$display("MISMATCH at %0t: case %0d field write %0d is %h, expected %h", $time,
					c, k, seen_fw[k], fw_tab[c][k]) ;
				errors++ ;
			end
		end
		checks++ ;
		assert (seen_land.size() > 0)
		else
		begin
			$display("case %0d: o_jump never went high, no branch was taken", c) ;
			errors++ ;
		end
		if (seen_land.size() > 0)
		begin
			checks++ ;
			assert (seen_land[0] == land_tab[c])
			else
			begin
				$display("MISMATCH at %0t: case %0d first branch landed at %0d, expected %0d",
					$time, c, seen_land[0], land_tab[c]) ;
				errors++ ;
			end
		end
		$display("case %0d %s: %0d outputs, %0d field writes", c,
			(errors == errs_before) ? "ok" : "BAD", seen_out.size(), seen_fw.size()) ;
	endtask

	initial
	begin
		reset = 1'b1 ;
		load_buffers = 1'b1 ;
		in0 = '0 ;
		in1 = '0 ;
		in2 = '0 ;
		for (int k = 0 ; k < PROG_WORDS ; k++)
			prog[k] = INSTR_NOP ;
		errors = 0 ;
		checks = 0 ;
		fill_case_table() ;
		for (int c = 0 ; c < NCASES ; c++)
			run_case(c) ;
		$display("%0d cases, %0d checks, %0d errors", NCASES, checks, errors) ;
		if (errors == 0)
			$display("Regression passed") ;
		else
			$display("Regression failed") ;
		$finish ;
	end

endmodule
